//--- src.f
design/dcache_pkg.sv
design/tlb_translate.sv
design/bank_split.sv
design/cache_bank.sv
design/output_align.sv
design/dcache_top.sv
dv/dcache_asserts.sv
dv/dcache_tb.sv

//--- dv/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
   import dcache_pkg::*;

   localparam logic [1:0] OP_NOP  = 2'd0;
   localparam logic [1:0] OP_RD   = 2'd1;
   localparam logic [1:0] OP_WR   = 2'd2;
   localparam logic [1:0] OP_FILL = 2'd3;

   // One stimulus row where fills put a paddr in addr
   typedef struct packed {
      logic [1:0]  op;
      logic [31:0] addr;
      logic [1:0]  size;
      logic [63:0] wdata;
      logic        miss;
      logic        prot;
      logic        hit;
   } row_t;

   typedef struct packed {
      logic [6:0]  ptcid;
      logic        miss;
      logic        prot;
      logic        hit;
      logic        chk_data;
      logic [63:0] data;
      logic [31:0] due;
   } resp_t;

   logic         clk = 1'b0;
   logic         arst_n_i;
   logic         req_valid_i;
   logic         req_write_i;
   vaddr_t       req_vaddr_i;
   size_t        req_size_i;
   data_t        req_wdata_i;
   ptcid_t       req_ptcid_i;
   vpn_t   [7:0] tlb_vp_i;
   frame_t [7:0] tlb_pf_i;
   logic   [7:0] tlb_v_i;
   logic   [7:0] tlb_p_i;
   logic   [7:0] tlb_rw_i;
   logic         fill_valid_i;
   paddr_t       fill_paddr_i;
   line_t        fill_data_i;
   logic         resp_valid_o;
   ptcid_t       resp_ptcid_o;
   data_t        resp_data_o;
   logic         resp_hit_o;
   logic         tlb_miss_o;
   logic         prot_exc_o;

   row_t         rows[$];
   resp_t        exp_q[$];
   resp_t        head;
   line_t        mdl_data [32];
   tag_t         mdl_tag  [32];
   logic [31:0]  mdl_valid;
   integer       seed;
   int           errors = 0;
   int           cyc = 0;

   dcache_top #(.TLB_ENTRIES(8)) DUT (.*);

   always #4 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         errors++;
         $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      end
   endtask

   task automatic add_row(input logic [1:0] op, input logic [31:0] addr, input logic [1:0] size,
                          input logic [63:0] wdata, input logic miss, prot, hit);
      rows.push_back('{op, addr, size, wdata, miss, prot, hit});
   endtask

   // Lowest matching entry wins
   function automatic paddr_t translate(input vaddr_t va);
      paddr_t pa;
      pa = {3'b000, va[11:0]};
      for (int k = 7; k >= 0; k--) begin
         if (tlb_v_i[k] && tlb_vp_i[k] == va[31:12]) pa = {tlb_pf_i[k], va[11:0]};
      end
      return pa;
   endfunction

   function automatic logic line_present(input paddr_t pa);
      return mdl_valid[pa[8:4]] && (mdl_tag[pa[8:4]] == pa[14:9]);
   endfunction

   // A write lands byte by byte in present lines only
   task automatic model_access(input paddr_t pa, input size_t size, input logic wr,
                               input data_t wdata, output data_t rd);
      paddr_t a;
      rd = '0;
      for (int b = 0; b < (1 << size); b++) begin
         a = pa + paddr_t'(b);
         if (wr && line_present(a)) begin
            mdl_data[a[8:4]][8*a[3:0] +: 8] = wdata[8*b +: 8];
         end
         rd[8*b +: 8] = mdl_data[a[8:4]][8*a[3:0] +: 8];
      end
   endtask

   task automatic load_table();
      // Faults
      add_row(OP_RD,   32'h0004_0000, 2'd3, 64'h0, 1'b1, 1'b0, 1'b0);
      add_row(OP_WR,   32'h0002_0100, 2'd2, 64'h55, 1'b0, 1'b1, 1'b0);
      add_row(OP_RD,   32'h0003_0000, 2'd0, 64'h0, 1'b0, 1'b1, 1'b0);
      // Cold miss, then fill and read every size
      add_row(OP_RD,   32'h0001_0000, 2'd3, 64'h0, 1'b0, 1'b0, 1'b0);
      add_row(OP_NOP,  32'h0,         2'd0, 64'h0, 1'b0, 1'b0, 1'b0);
      add_row(OP_FILL, 32'h0000_1000, 2'd0, 64'h0, 1'b0, 1'b0, 1'b0);
      add_row(OP_FILL, 32'h0000_2100, 2'd0, 64'h0, 1'b0, 1'b0, 1'b0);
      add_row(OP_RD,   32'h0001_0000, 2'd0, 64'h0, 1'b0, 1'b0, 1'b1);
      add_row(OP_RD,   32'h0001_0003, 2'd1, 64'h0, 1'b0, 1'b0, 1'b1);
      add_row(OP_RD,   32'h0001_0004, 2'd2, 64'h0, 1'b0, 1'b0, 1'b1);
      add_row(OP_RD,   32'h0002_0106, 2'd1, 64'h0, 1'b0, 1'b0, 1'b1);
      // Line crossings from even to odd and odd to even
      add_row(OP_RD,   32'h0001_000c, 2'd3, 64'h0, 1'b0, 1'b0, 1'b0);
      add_row(OP_NOP,  32'h0,         2'd0, 64'h0, 1'b0, 1'b0, 1'b0);
      add_row(OP_FILL, 32'h0000_1010, 2'd0, 64'h0, 1'b0, 1'b0, 1'b0);
      add_row(OP_FILL, 32'h0000_1030, 2'd0, 64'h0, 1'b0, 1'b0, 1'b0);
      add_row(OP_RD,   32'h0001_000c, 2'd3, 64'h0, 1'b0, 1'b0, 1'b1);
      add_row(OP_RD,   32'h0001_003a, 2'd3, 64'h0, 1'b0, 1'b0, 1'b0);
      add_row(OP_NOP,  32'h0,         2'd0, 64'h0, 1'b0, 1'b0, 1'b0);
      add_row(OP_FILL, 32'h0000_1040, 2'd0, 64'h0, 1'b0, 1'b0, 1'b0);
      add_row(OP_RD,   32'h0001_003f, 2'd1, 64'h0, 1'b0, 1'b0, 1'b1);
      // Write hits merge while a write miss leaves its set untouched
      add_row(OP_WR,   32'h0001_0006, 2'd1, 64'hbeef, 1'b0, 1'b0, 1'b1);
      add_row(OP_WR,   32'h0001_000e, 2'd2, 64'h1122_3344, 1'b0, 1'b0, 1'b1);
      add_row(OP_RD,   32'h0001_0000, 2'd3, 64'h0, 1'b0, 1'b0, 1'b1);
      add_row(OP_RD,   32'h0001_000c, 2'd3, 64'h0, 1'b0, 1'b0, 1'b1);
      // Same even set as 0x1000 with another tag
      add_row(OP_WR,   32'h0001_0200, 2'd3, 64'h0123_4567_89ab_cdef, 1'b0, 1'b0, 1'b0);
      add_row(OP_RD,   32'h0001_0000, 2'd3, 64'h0, 1'b0, 1'b0, 1'b1);
      add_row(OP_NOP,  32'h0,         2'd0, 64'h0, 1'b0, 1'b0, 1'b0);
      add_row(OP_FILL, 32'h0000_1200, 2'd0, 64'h0, 1'b0, 1'b0, 1'b0);
      add_row(OP_RD,   32'h0001_0200, 2'd3, 64'h0, 1'b0, 1'b0, 1'b1);
   endtask

   // Responses compared in order on the falling edge
   always @(negedge clk) begin
      if (resp_valid_o) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("ERROR at %0t: a response arrived with no request outstanding", $time);
         end else begin
            head = exp_q.pop_front();
            check_value("resp_latency", head.due, cyc);
            check_value("resp_ptcid_o", head.ptcid, resp_ptcid_o);
            check_value("tlb_miss_o", head.miss, tlb_miss_o);
            check_value("prot_exc_o", head.prot, prot_exc_o);
            check_value("resp_hit_o", head.hit, resp_hit_o);
            if (head.chk_data) check_value("resp_data_o", head.data, resp_data_o);
         end
      end else begin
         check_value("tlb_miss_o", 1'b0, tlb_miss_o);
         check_value("prot_exc_o", 1'b0, prot_exc_o);
      end
   end

   initial begin
      row_t   r;
      resp_t  e;
      paddr_t pa;
      data_t  rd;
      int     wait_cycles;
      seed = 82;
      arst_n_i = 1'b0;
      req_valid_i = 1'b0;
      req_write_i = 1'b0;
      req_vaddr_i = '0;
      req_size_i = '0;
      req_wdata_i = '0;
      req_ptcid_i = '0;
      fill_valid_i = 1'b0;
      fill_paddr_i = '0;
      fill_data_i = '0;
      mdl_valid = '0;
      // Writable, read-only and non-present pages
      tlb_vp_i = '0;
      tlb_pf_i = '0;
      tlb_v_i = 8'b0000_0111;
      tlb_p_i = 8'b0000_0011;
      tlb_rw_i = 8'b0000_0001;
      tlb_vp_i[0] = 20'h00010;
      tlb_pf_i[0] = 3'd1;
      tlb_vp_i[1] = 20'h00020;
      tlb_pf_i[1] = 3'd2;
      tlb_vp_i[2] = 20'h00030;
      tlb_pf_i[2] = 3'd3;
      load_table();
      repeat (8) @(posedge clk);
      #1 arst_n_i = 1'b1;
      repeat (2) @(posedge clk);
      for (int i = 0; i < rows.size(); i++) begin
         @(posedge clk);
         #1;
         r = rows[i];
         req_valid_i = (r.op == OP_RD) || (r.op == OP_WR);
         req_write_i = (r.op == OP_WR);
         req_vaddr_i = r.addr;
         req_size_i = r.size;
         req_wdata_i = r.wdata;
         req_ptcid_i = 7'(i);
         fill_valid_i = (r.op == OP_FILL);
         fill_paddr_i = r.addr[14:0];
         if (r.op == OP_FILL) begin
            fill_data_i = {$random(seed), $random(seed), $random(seed), $random(seed)};
            mdl_data[r.addr[8:4]] = fill_data_i;
            mdl_tag[r.addr[8:4]] = r.addr[14:9];
            mdl_valid[r.addr[8:4]] = 1'b1;
         end
         if (req_valid_i) begin
            pa = translate(r.addr);
            rd = '0;
            if (!r.miss && !r.prot) model_access(pa, r.size, req_write_i, r.wdata, rd);
            e = '{7'(i), r.miss, r.prot, r.hit, !req_write_i && r.hit, rd, cyc + 4};
            exp_q.push_back(e);
         end
      end
      @(posedge clk);
      #1;
      req_valid_i = 1'b0;
      fill_valid_i = 1'b0;
      wait_cycles = 0;
      while (exp_q.size() != 0 && wait_cycles < 20) begin
         @(posedge clk);
         wait_cycles++;
      end
      if (exp_q.size() != 0) begin
         $display("Timeout: %0d responses never arrived, errors so far %0d",
                  exp_q.size(), errors);
         $display("TB FAILED");
         $finish;
      end else begin
         $display("Checks done, errors: %0d", errors);
         if (errors == 0) begin
            $display("TB PASSED");
         end else begin
            $display("TB FAILED");
         end
         $finish;
      end
   end

endmodule

//--- dv/dcache_asserts.sv
`timescale 1ns/1ps

module dcache_asserts (
   input logic clk,
   input logic arst_n_i,
   input logic req_valid_i,
   input logic resp_valid_o,
   input logic resp_hit_o,
   input logic tlb_miss_o,
   input logic prot_exc_o
);

   // Four register stages from request to response
   a_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
      resp_valid_o == $past(req_valid_i, 4))
      else $error("resp_valid_o does not follow req_valid_i by four cycles");

   a_fault_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
      (tlb_miss_o || prot_exc_o) |-> resp_valid_o)
      else $error("fault flag raised without resp_valid_o");

   a_hit_no_fault: assert property (@(posedge clk) disable iff (!arst_n_i)
      !(resp_hit_o && (tlb_miss_o || prot_exc_o)))
      else $error("resp_hit_o raised together with a fault");

endmodule

bind dcache_top dcache_asserts u_asserts (
   .clk(clk), .arst_n_i(arst_n_i), .req_valid_i(req_valid_i), .resp_valid_o(resp_valid_o),
   .resp_hit_o(resp_hit_o), .tlb_miss_o(tlb_miss_o), .prot_exc_o(prot_exc_o)
);

//--- design/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
   parameter int TLB_ENTRIES = 8
) (
   input  logic                                 clk,
   input  logic                                 arst_n_i,
   input  logic                                 req_valid_i,
   input  logic                                 req_write_i,
   input  dcache_pkg::vaddr_t                   req_vaddr_i,
   input  dcache_pkg::size_t                    req_size_i,
   input  dcache_pkg::data_t                    req_wdata_i,
   input  dcache_pkg::ptcid_t                   req_ptcid_i,
   input  dcache_pkg::vpn_t   [TLB_ENTRIES-1:0] tlb_vp_i,
   input  dcache_pkg::frame_t [TLB_ENTRIES-1:0] tlb_pf_i,
   input  logic               [TLB_ENTRIES-1:0] tlb_v_i,
   input  logic               [TLB_ENTRIES-1:0] tlb_p_i,
   input  logic               [TLB_ENTRIES-1:0] tlb_rw_i,
   input  logic                                 fill_valid_i,
   input  dcache_pkg::paddr_t                   fill_paddr_i,
   input  dcache_pkg::line_t                    fill_data_i,
   output logic                                 resp_valid_o,
   output dcache_pkg::ptcid_t                   resp_ptcid_o,
   output dcache_pkg::data_t                    resp_data_o,
   output logic                                 resp_hit_o,
   output logic                                 tlb_miss_o,
   output logic                                 prot_exc_o
);
   import dcache_pkg::*;

   logic     tr_valid, tr_write, tr_miss, tr_prot;
   paddr_t   tr_paddr;
   size_t    tr_size;
   data_t    tr_wdata;
   ptcid_t   tr_ptcid;

   logic     sp_valid, sp_write, sp_miss, sp_prot, sp_first_odd;
   logic     sp_even_req, sp_odd_req;
   ptcid_t   sp_ptcid;
   ofs_t     sp_ofs;
   size_t    sp_size;
   paddr_t   sp_even_addr, sp_odd_addr;
   byte_en_t sp_even_be, sp_odd_be;
   line_t    sp_even_wdata, sp_odd_wdata;

   // Fields riding alongside the bank stage
   logic     st_valid, st_write, st_miss, st_prot, st_first_odd;
   logic     st_even_req, st_odd_req;
   ptcid_t   st_ptcid;
   ofs_t     st_ofs;
   size_t    st_size;

   logic     even_hit, odd_hit;
   line_t    even_line, odd_line;
   logic     fill_even, fill_odd;

   assign fill_even = fill_valid_i & ~fill_paddr_i[BANK_BIT];
   assign fill_odd  = fill_valid_i & fill_paddr_i[BANK_BIT];

   tlb_translate #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb (
      .clk(clk), .arst_n_i(arst_n_i),
      .req_valid_i(req_valid_i), .req_write_i(req_write_i), .req_vaddr_i(req_vaddr_i),
      .req_size_i(req_size_i), .req_wdata_i(req_wdata_i), .req_ptcid_i(req_ptcid_i),
      .tlb_vp_i(tlb_vp_i), .tlb_pf_i(tlb_pf_i),
      .tlb_v_i(tlb_v_i), .tlb_p_i(tlb_p_i), .tlb_rw_i(tlb_rw_i),
      .tr_valid_o(tr_valid), .tr_write_o(tr_write), .tr_paddr_o(tr_paddr),
      .tr_size_o(tr_size), .tr_wdata_o(tr_wdata), .tr_ptcid_o(tr_ptcid),
      .tr_miss_o(tr_miss), .tr_prot_o(tr_prot)
   );

   bank_split u_split (
      .clk(clk), .arst_n_i(arst_n_i),
      .tr_valid_i(tr_valid), .tr_write_i(tr_write), .tr_paddr_i(tr_paddr),
      .tr_size_i(tr_size), .tr_wdata_i(tr_wdata), .tr_ptcid_i(tr_ptcid),
      .tr_miss_i(tr_miss), .tr_prot_i(tr_prot),
      .sp_valid_o(sp_valid), .sp_write_o(sp_write), .sp_ptcid_o(sp_ptcid),
      .sp_miss_o(sp_miss), .sp_prot_o(sp_prot), .sp_ofs_o(sp_ofs), .sp_size_o(sp_size),
      .sp_even_req_o(sp_even_req), .sp_odd_req_o(sp_odd_req),
      .sp_even_addr_o(sp_even_addr), .sp_odd_addr_o(sp_odd_addr),
      .sp_even_be_o(sp_even_be), .sp_odd_be_o(sp_odd_be),
      .sp_even_wdata_o(sp_even_wdata), .sp_odd_wdata_o(sp_odd_wdata),
      .sp_first_odd_o(sp_first_odd)
   );

   cache_bank bank_even (
      .clk(clk), .arst_n_i(arst_n_i),
      .acc_req_i(sp_even_req), .acc_write_i(sp_write), .acc_addr_i(sp_even_addr),
      .acc_be_i(sp_even_be), .acc_wdata_i(sp_even_wdata),
      .fill_we_i(fill_even), .fill_addr_i(fill_paddr_i), .fill_data_i(fill_data_i),
      .acc_hit_o(even_hit), .acc_line_o(even_line)
   );

   cache_bank bank_odd (
      .clk(clk), .arst_n_i(arst_n_i),
      .acc_req_i(sp_odd_req), .acc_write_i(sp_write), .acc_addr_i(sp_odd_addr),
      .acc_be_i(sp_odd_be), .acc_wdata_i(sp_odd_wdata),
      .fill_we_i(fill_odd), .fill_addr_i(fill_paddr_i), .fill_data_i(fill_data_i),
      .acc_hit_o(odd_hit), .acc_line_o(odd_line)
   );

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         st_valid    <= 1'b0;
         st_miss     <= 1'b0;
         st_prot     <= 1'b0;
         st_even_req <= 1'b0;
         st_odd_req  <= 1'b0;
      end else begin
         st_valid    <= sp_valid;
         st_miss     <= sp_miss;
         st_prot     <= sp_prot;
         st_even_req <= sp_even_req;
         st_odd_req  <= sp_odd_req;
      end
   end

   always_ff @(posedge clk) begin
      st_write     <= sp_write;
      st_ptcid     <= sp_ptcid;
      st_ofs       <= sp_ofs;
      st_size      <= sp_size;
      st_first_odd <= sp_first_odd;
   end

   output_align u_align (
      .clk(clk), .arst_n_i(arst_n_i),
      .st_valid_i(st_valid), .st_write_i(st_write), .st_ptcid_i(st_ptcid),
      .st_miss_i(st_miss), .st_prot_i(st_prot), .st_ofs_i(st_ofs), .st_size_i(st_size),
      .st_first_odd_i(st_first_odd), .st_even_req_i(st_even_req), .st_odd_req_i(st_odd_req),
      .even_hit_i(even_hit), .even_line_i(even_line),
      .odd_hit_i(odd_hit), .odd_line_i(odd_line),
      .resp_valid_o(resp_valid_o), .resp_ptcid_o(resp_ptcid_o), .resp_data_o(resp_data_o),
      .resp_hit_o(resp_hit_o), .tlb_miss_o(tlb_miss_o), .prot_exc_o(prot_exc_o)
   );

endmodule

//--- design/output_align.sv
`timescale 1ns/1ps

module output_align (
   input  logic                clk,
   input  logic                arst_n_i,
   input  logic                st_valid_i,
   input  logic                st_write_i,
   input  dcache_pkg::ptcid_t  st_ptcid_i,
   input  logic                st_miss_i,
   input  logic                st_prot_i,
   input  dcache_pkg::ofs_t    st_ofs_i,
   input  dcache_pkg::size_t   st_size_i,
   input  logic                st_first_odd_i,
   input  logic                st_even_req_i,
   input  logic                st_odd_req_i,
   input  logic                even_hit_i,
   input  dcache_pkg::line_t   even_line_i,
   input  logic                odd_hit_i,
   input  dcache_pkg::line_t   odd_line_i,
   output logic                resp_valid_o,
   output dcache_pkg::ptcid_t  resp_ptcid_o,
   output dcache_pkg::data_t   resp_data_o,
   output logic                resp_hit_o,
   output logic                tlb_miss_o,
   output logic                prot_exc_o
);
   import dcache_pkg::*;

   logic [2*LINE_W-1:0] pair;
   logic [2*LINE_W-1:0] shifted;
   data_t               size_mask;
   logic                hit;

   // Second line sits above the first
   assign pair    = st_first_odd_i ? {even_line_i, odd_line_i} : {odd_line_i, even_line_i};
   assign shifted = pair >> {st_ofs_i, 3'b000};

   always_comb begin
      case (st_size_i)
         2'd0:    size_mask = data_t'(64'h0000_0000_0000_00ff);
         2'd1:    size_mask = data_t'(64'h0000_0000_0000_ffff);
         2'd2:    size_mask = data_t'(64'h0000_0000_ffff_ffff);
         default: size_mask = '1;
      endcase
   end

   // Faults leave both requests low and so give no hit
   assign hit = (st_even_req_i | st_odd_req_i) &
                (~st_even_req_i | even_hit_i) &
                (~st_odd_req_i | odd_hit_i);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         resp_valid_o <= 1'b0;
         resp_hit_o   <= 1'b0;
         tlb_miss_o   <= 1'b0;
         prot_exc_o   <= 1'b0;
      end else begin
         resp_valid_o <= st_valid_i;
         resp_hit_o   <= st_valid_i & hit;
         tlb_miss_o   <= st_miss_i;
         prot_exc_o   <= st_prot_i;
      end
   end

   always_ff @(posedge clk) begin
      resp_ptcid_o <= st_ptcid_i;
      resp_data_o  <= st_write_i ? '0 : (shifted[DATA_W-1:0] & size_mask);
   end

endmodule

//--- design/cache_bank.sv
`timescale 1ns/1ps

module cache_bank (
   input  logic                 clk,
   input  logic                 arst_n_i,
   input  logic                 acc_req_i,
   input  logic                 acc_write_i,
   input  dcache_pkg::paddr_t   acc_addr_i,
   input  dcache_pkg::byte_en_t acc_be_i,
   input  dcache_pkg::line_t    acc_wdata_i,
   input  logic                 fill_we_i,
   input  dcache_pkg::paddr_t   fill_addr_i,
   input  dcache_pkg::line_t    fill_data_i,
   output logic                 acc_hit_o,
   output dcache_pkg::line_t    acc_line_o
);
   import dcache_pkg::*;

   localparam int SETS = 2 ** INDEX_W;

   line_t           data_q [SETS];
   tag_t            tag_q  [SETS];
   logic [SETS-1:0] valid_q;

   index_t          acc_idx;
   tag_t            acc_tag;
   index_t          fill_idx;
   tag_t            fill_tag;
   logic            hit;

   assign acc_idx  = acc_addr_i[INDEX_LSB +: INDEX_W];
   assign acc_tag  = acc_addr_i[TAG_LSB +: TAG_W];
   assign fill_idx = fill_addr_i[INDEX_LSB +: INDEX_W];
   assign fill_tag = fill_addr_i[TAG_LSB +: TAG_W];

   // Lookup uses the state from before any fill at this edge
   assign hit = acc_req_i & valid_q[acc_idx] & (tag_q[acc_idx] == acc_tag);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q   <= '0;
         acc_hit_o <= 1'b0;
      end else begin
         acc_hit_o <= hit;
         if (fill_we_i) begin
            valid_q[fill_idx] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (acc_req_i) begin
         acc_line_o <= data_q[acc_idx];
      end

      // Write-no-allocate, only a hit merges bytes
      if (hit && acc_write_i) begin
         for (int b = 0; b < LINE_BYTES; b++) begin
            if (acc_be_i[b]) begin
               data_q[acc_idx][8*b +: 8] <= acc_wdata_i[8*b +: 8];
            end
         end
      end

      // Full line from the fill port, last so it wins on a clash
      if (fill_we_i) begin
         data_q[fill_idx] <= fill_data_i;
         tag_q[fill_idx]  <= fill_tag;
      end
   end

endmodule

//--- design/bank_split.sv
`timescale 1ns/1ps

module bank_split (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic                   tr_valid_i,
   input  logic                   tr_write_i,
   input  dcache_pkg::paddr_t     tr_paddr_i,
   input  dcache_pkg::size_t      tr_size_i,
   input  dcache_pkg::data_t      tr_wdata_i,
   input  dcache_pkg::ptcid_t     tr_ptcid_i,
   input  logic                   tr_miss_i,
   input  logic                   tr_prot_i,
   output logic                   sp_valid_o,
   output logic                   sp_write_o,
   output dcache_pkg::ptcid_t     sp_ptcid_o,
   output logic                   sp_miss_o,
   output logic                   sp_prot_o,
   output dcache_pkg::ofs_t       sp_ofs_o,
   output dcache_pkg::size_t      sp_size_o,
   output logic                   sp_even_req_o,
   output logic                   sp_odd_req_o,
   output dcache_pkg::paddr_t     sp_even_addr_o,
   output dcache_pkg::paddr_t     sp_odd_addr_o,
   output dcache_pkg::byte_en_t   sp_even_be_o,
   output dcache_pkg::byte_en_t   sp_odd_be_o,
   output dcache_pkg::line_t      sp_even_wdata_o,
   output dcache_pkg::line_t      sp_odd_wdata_o,
   output logic                   sp_first_odd_o
);
   import dcache_pkg::*;

   localparam int WIN_W = 2 * LINE_BYTES;

   ofs_t                ofs;
   logic [3:0]          nbytes;
   logic [WIN_W-1:0]    window;
   logic [2*LINE_W-1:0] lanes;
   paddr_t              first_addr;
   paddr_t              second_addr;
   logic                first_odd;
   logic                no_fault;
   byte_en_t            even_be;
   byte_en_t            odd_be;

   assign ofs    = tr_paddr_i[OFS_W-1:0];
   assign nbytes = 4'd1 << tr_size_i;

   // Byte window over two consecutive lines, low half is the first line
   assign window = ((WIN_W'(1) << nbytes) - WIN_W'(1)) << ofs;
   assign lanes  = {{(2*LINE_W-DATA_W){1'b0}}, tr_wdata_i} << {ofs, 3'b000};

   assign first_addr  = {tr_paddr_i[PADDR_W-1:OFS_W], {OFS_W{1'b0}}};
   assign second_addr = first_addr + paddr_t'(LINE_BYTES);
   assign first_odd   = tr_paddr_i[BANK_BIT];
   assign no_fault    = tr_valid_i & ~tr_miss_i & ~tr_prot_i;

   assign even_be = first_odd ? window[WIN_W-1:LINE_BYTES] : window[LINE_BYTES-1:0];
   assign odd_be  = first_odd ? window[LINE_BYTES-1:0] : window[WIN_W-1:LINE_BYTES];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sp_valid_o    <= 1'b0;
         sp_miss_o     <= 1'b0;
         sp_prot_o     <= 1'b0;
         sp_even_req_o <= 1'b0;
         sp_odd_req_o  <= 1'b0;
      end else begin
         sp_valid_o    <= tr_valid_i;
         sp_miss_o     <= tr_miss_i;
         sp_prot_o     <= tr_prot_i;
         sp_even_req_o <= no_fault & (|even_be);
         sp_odd_req_o  <= no_fault & (|odd_be);
      end
   end

   always_ff @(posedge clk) begin
      sp_write_o      <= tr_write_i;
      sp_ptcid_o      <= tr_ptcid_i;
      sp_ofs_o        <= ofs;
      sp_size_o       <= tr_size_i;
      sp_first_odd_o  <= first_odd;
      sp_even_be_o    <= even_be;
      sp_odd_be_o     <= odd_be;
      sp_even_addr_o  <= first_odd ? second_addr : first_addr;
      sp_odd_addr_o   <= first_odd ? first_addr : second_addr;
      sp_even_wdata_o <= first_odd ? lanes[2*LINE_W-1:LINE_W] : lanes[LINE_W-1:0];
      sp_odd_wdata_o  <= first_odd ? lanes[LINE_W-1:0] : lanes[2*LINE_W-1:LINE_W];
   end

endmodule

//--- design/tlb_translate.sv
`timescale 1ns/1ps

module tlb_translate #(
   parameter int TLB_ENTRIES = 8
) (
   input  logic                                 clk,
   input  logic                                 arst_n_i,
   input  logic                                 req_valid_i,
   input  logic                                 req_write_i,
   input  dcache_pkg::vaddr_t                   req_vaddr_i,
   input  dcache_pkg::size_t                    req_size_i,
   input  dcache_pkg::data_t                    req_wdata_i,
   input  dcache_pkg::ptcid_t                   req_ptcid_i,
   input  dcache_pkg::vpn_t   [TLB_ENTRIES-1:0] tlb_vp_i,
   input  dcache_pkg::frame_t [TLB_ENTRIES-1:0] tlb_pf_i,
   input  logic               [TLB_ENTRIES-1:0] tlb_v_i,
   input  logic               [TLB_ENTRIES-1:0] tlb_p_i,
   input  logic               [TLB_ENTRIES-1:0] tlb_rw_i,
   output logic                                 tr_valid_o,
   output logic                                 tr_write_o,
   output dcache_pkg::paddr_t                   tr_paddr_o,
   output dcache_pkg::size_t                    tr_size_o,
   output dcache_pkg::data_t                    tr_wdata_o,
   output dcache_pkg::ptcid_t                   tr_ptcid_o,
   output logic                                 tr_miss_o,
   output logic                                 tr_prot_o
);
   import dcache_pkg::*;

   vpn_t   req_vpn;
   logic   match;
   frame_t match_frame;
   logic   match_p;
   logic   match_rw;
   logic   fault_prot;

   assign req_vpn = req_vaddr_i[VADDR_W-1:PAGE_OFS_W];

   // Scan downwards so the lowest matching entry is the one kept
   always_comb begin
      match       = 1'b0;
      match_frame = '0;
      match_p     = 1'b0;
      match_rw    = 1'b0;
      for (int k = TLB_ENTRIES - 1; k >= 0; k--) begin
         if (tlb_v_i[k] && (tlb_vp_i[k] == req_vpn)) begin
            match       = 1'b1;
            match_frame = tlb_pf_i[k];
            match_p     = tlb_p_i[k];
            match_rw    = tlb_rw_i[k];
         end
      end
   end

   // Not present, or a store to a read-only page
   assign fault_prot = match & (~match_p | (req_write_i & ~match_rw));

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tr_valid_o <= 1'b0;
         tr_miss_o  <= 1'b0;
         tr_prot_o  <= 1'b0;
      end else begin
         tr_valid_o <= req_valid_i;
         tr_miss_o  <= req_valid_i & ~match;
         tr_prot_o  <= req_valid_i & fault_prot;
      end
   end

   always_ff @(posedge clk) begin
      tr_write_o <= req_write_i;
      tr_paddr_o <= {match_frame, req_vaddr_i[PAGE_OFS_W-1:0]};
      tr_size_o  <= req_size_i;
      tr_wdata_o <= req_wdata_i;
      tr_ptcid_o <= req_ptcid_i;
   end

endmodule

//--- design/dcache_pkg.sv
package dcache_pkg;

   // Address layout
   localparam int VADDR_W    = 32;
   localparam int PADDR_W    = 15;
   localparam int PAGE_OFS_W = 12;
   localparam int FRAME_W    = PADDR_W - PAGE_OFS_W;
   localparam int VPN_W      = VADDR_W - PAGE_OFS_W;

   // Line geometry
   localparam int LINE_BYTES = 16;
   localparam int LINE_W     = LINE_BYTES * 8;
   localparam int OFS_W      = 4;
   localparam int INDEX_W    = 4;
   localparam int TAG_W      = 6;

   // Bit 4 picks the bank, 8:5 the set, 14:9 the tag
   localparam int BANK_BIT   = OFS_W;
   localparam int INDEX_LSB  = BANK_BIT + 1;
   localparam int TAG_LSB    = INDEX_LSB + INDEX_W;

   localparam int DATA_W     = 64;

   typedef logic [VADDR_W-1:0]    vaddr_t;
   typedef logic [PADDR_W-1:0]    paddr_t;
   typedef logic [LINE_W-1:0]     line_t;
   typedef logic [DATA_W-1:0]     data_t;

   typedef logic [TAG_W-1:0]      tag_t;
   typedef logic [INDEX_W-1:0]    index_t;
   typedef logic [OFS_W-1:0]      ofs_t;

   // One enable per line byte
   typedef logic [LINE_BYTES-1:0] byte_en_t;

   // Access is 2**size bytes
   typedef logic [1:0]            size_t;

   typedef logic [6:0]            ptcid_t;

   typedef logic [VPN_W-1:0]      vpn_t;
   typedef logic [FRAME_W-1:0]    frame_t;

endpackage
